// ==== source/trig_cfg.svh ====
`ifndef TRIG_CFG_SVH
`define TRIG_CFG_SVH

// samples per input word
`define TRIG_LANES 4
`define TRIG_SAMPLE_W 12
// each sample sits left-justified in its lane
`define TRIG_LANE_W 16

// capture window in words
`define TRIG_PRE_WORDS 4
`define TRIG_POST_WORDS 12
`define TRIG_CAP_WORDS (`TRIG_PRE_WORDS + `TRIG_POST_WORDS)
// header plus the captured words
`define TRIG_EVT_WORDS (`TRIG_CAP_WORDS + 1)

// baseline is the mean of 2**TRIG_BASE_LOG2 word minima
`define TRIG_BASE_LOG2 3
`define TRIG_THRESHOLD 200

`define TRIG_FIFO_DEPTH 64
`define TRIG_TS_W 16

`endif

// ==== source/trig_sample_pkg.sv ====
`default_nettype none

`include "trig_cfg.svh"

package trig_sample_pkg;

    typedef logic signed [`TRIG_SAMPLE_W-1:0] sample_t;
    typedef logic [`TRIG_LANES*`TRIG_LANE_W-1:0] word_t;
    typedef logic [`TRIG_TS_W-1:0] ts_t;
    typedef logic [31:0] evt_idx_t;

    // frame header, event index in the upper half
    typedef struct packed {
        evt_idx_t   evt_idx;
        logic [3:0] rsvd;
        sample_t    baseline;
        ts_t        ts;
    } header_t;

endpackage

`default_nettype wire

// ==== source/trig_ctrl_pkg.sv ====
`default_nettype none

package trig_ctrl_pkg;

    typedef enum logic {
        LEARN,
        HOLD
    } base_state_t;

    typedef enum logic [1:0] {
        WAIT_BASE,
        ARMED,
        CAPTURE
    } trig_state_t;

    // tag stored next to every FIFO word
    typedef enum logic [1:0] {
        HEADER,
        DATA,
        TAIL
    } word_kind_t;

endpackage

`default_nettype wire

// ==== source/adc_word_front.sv ====
`default_nettype none

`include "trig_cfg.svh"

module adc_word_front (
    input  wire                            axis_aclk,
    input  wire                            rst,
    input  wire                            in_valid,
    input  wire trig_sample_pkg::word_t    in_data,
    output logic                           word_valid,
    output trig_sample_pkg::sample_t       word_min,
    output trig_sample_pkg::word_t         delayed_word
);
    import trig_sample_pkg::*;

    localparam int LANES = `TRIG_LANES;
    localparam int PRE   = `TRIG_PRE_WORDS;
    // low lane bits below the sample
    localparam int SKIP  = `TRIG_LANE_W - `TRIG_SAMPLE_W;

    // hist[0] is the current word, hist[PRE] the oldest one
    word_t   hist [PRE+1];
    // heap-ordered min tree, leaves start at LANES-1
    sample_t node [2*LANES-1];

    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            word_valid <= 1'b0;
            for (int i = 0; i <= PRE; i++)
            begin
                hist[i] <= '0;
            end
        end
        else
        begin
            word_valid <= in_valid;
            if (in_valid)
            begin
                hist[0] <= in_data;
                for (int i = 1; i <= PRE; i++)
                begin
                    hist[i] <= hist[i-1];
                end
            end
        end
    end

    always_comb
    begin
        for (int l = 0; l < LANES; l++)
        begin
            node[LANES-1+l] = sample_t'(hist[0][l*`TRIG_LANE_W+SKIP +: `TRIG_SAMPLE_W]);
        end
        // reduce pairwise toward the root
        for (int n = LANES - 2; n >= 0; n--)
        begin
            node[n] = (node[2*n+1] < node[2*n+2]) ? node[2*n+1] : node[2*n+2];
        end
    end

    assign word_min     = node[0];
    assign delayed_word = hist[PRE];

endmodule

`default_nettype wire

// ==== source/baseline_tracker.sv ====
`default_nettype none

`include "trig_cfg.svh"

module baseline_tracker (
    input  wire                             axis_aclk,
    input  wire                             rst,
    input  wire                             word_valid,
    input  wire trig_sample_pkg::sample_t   word_min,
    output logic                            base_ready,
    output trig_sample_pkg::sample_t        baseline
);
    import trig_sample_pkg::*;
    import trig_ctrl_pkg::*;

    localparam int N_LOG2 = `TRIG_BASE_LOG2;
    localparam int ACC_W  = `TRIG_SAMPLE_W + N_LOG2;

    base_state_t             state;
    logic [N_LOG2-1:0]       word_cnt;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] min_ext;
    logic signed [ACC_W-1:0] acc_next;
    logic                    last_word;

    assign min_ext   = {{N_LOG2{word_min[`TRIG_SAMPLE_W-1]}}, word_min};
    assign acc_next  = acc + min_ext;
    assign last_word = (state == LEARN) && word_valid && (word_cnt == '1);

    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            state    <= LEARN;
            word_cnt <= '0;
            acc      <= '0;
        end
        else if (state == LEARN && word_valid)
        begin
            acc      <= acc_next;
            word_cnt <= word_cnt + 1'b1;
            if (last_word)
                state <= HOLD;
        end
    end

    // arithmetic shift gives the floor of the mean
    always_ff @(posedge axis_aclk)
    begin
        if (last_word)
            baseline <= sample_t'(acc_next >>> N_LOG2);
    end

    // frozen once learned
    assign base_ready = (state == HOLD);

endmodule

`default_nettype wire

// ==== source/trigger_fsm.sv ====
`default_nettype none

`include "trig_cfg.svh"

module trigger_fsm (
    input  wire                             axis_aclk,
    input  wire                             rst,
    input  wire                             word_valid,
    input  wire trig_sample_pkg::sample_t   word_min,
    input  wire trig_sample_pkg::word_t     delayed_word,
    input  wire                             base_ready,
    input  wire trig_sample_pkg::sample_t   baseline,
    input  wire                             space_ok,
    output logic                            wr_en,
    output trig_sample_pkg::word_t          wr_data,
    output trig_ctrl_pkg::word_kind_t       wr_kind
);
    import trig_sample_pkg::*;
    import trig_ctrl_pkg::*;

    localparam int CAP_WORDS = `TRIG_CAP_WORDS;
    localparam int CNT_W     = $clog2(CAP_WORDS);
    localparam int LVL_W     = `TRIG_SAMPLE_W + 1;

    trig_state_t             state;
    ts_t                     word_idx;
    evt_idx_t                evt_idx;
    logic                    hist_ok;
    logic [CNT_W-1:0]        cap_cnt;
    word_t                   prev_word;
    logic signed [LVL_W-1:0] level_wide;
    sample_t                 level;
    logic                    trig_hit;
    logic                    evt_start;
    header_t                 hdr;

    // trigger level, clamped at the most negative sample
    assign level_wide = $signed({baseline[`TRIG_SAMPLE_W-1], baseline})
                      - LVL_W'(`TRIG_THRESHOLD);
    assign level = (level_wide[LVL_W-1] != level_wide[LVL_W-2])
                 ? sample_t'({1'b1, {(`TRIG_SAMPLE_W-1){1'b0}}})
                 : sample_t'(level_wide);
    assign trig_hit = (word_min < level);

    // accepted trigger, header goes out this cycle
    assign evt_start = word_valid && (state == ARMED) && hist_ok && trig_hit && space_ok;

    always_comb
    begin
        hdr.evt_idx  = evt_idx;
        hdr.rsvd     = '0;
        hdr.baseline = baseline;
        hdr.ts       = word_idx;
    end

    assign wr_en   = evt_start || (word_valid && state == CAPTURE);
    assign wr_data = (state == CAPTURE) ? prev_word : word_t'(hdr);

    always_comb
    begin
        if (state != CAPTURE)
            wr_kind = HEADER;
        else if (cap_cnt == CNT_W'(CAP_WORDS - 1))
            wr_kind = TAIL;
        else
            wr_kind = DATA;
    end

    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            state    <= WAIT_BASE;
            word_idx <= '0;
            evt_idx  <= '0;
            hist_ok  <= 1'b0;
            cap_cnt  <= '0;
        end
        else
        begin
            if (word_valid)
            begin
                word_idx <= word_idx + 1'b1;
                if (word_idx == ts_t'(`TRIG_PRE_WORDS - 1))
                    hist_ok <= 1'b1;
            end
            unique case (state)
                WAIT_BASE:
                begin
                    if (base_ready)
                        state <= ARMED;
                end
                ARMED:
                begin
                    if (evt_start)
                    begin
                        evt_idx <= evt_idx + 1'b1;
                        cap_cnt <= '0;
                        state   <= CAPTURE;
                    end
                end
                CAPTURE:
                begin
                    // new triggers are ignored until the tail is written
                    if (word_valid)
                    begin
                        cap_cnt <= cap_cnt + 1'b1;
                        if (wr_kind == TAIL)
                            state <= ARMED;
                    end
                end
                default:
                begin
                    state <= WAIT_BASE;
                end
            endcase
        end
    end

    // one word behind, so the first data word is the trigger word's oldest history
    always_ff @(posedge axis_aclk)
    begin
        if (word_valid)
            prev_word <= delayed_word;
    end

endmodule

`default_nettype wire

// ==== source/event_fifo.sv ====
`default_nettype none

`include "trig_cfg.svh"

module event_fifo (
    input  wire                              axis_aclk,
    input  wire                              rst,
    input  wire                              wr_en,
    input  wire trig_sample_pkg::word_t      wr_data,
    input  wire trig_ctrl_pkg::word_kind_t   wr_kind,
    input  wire                              rd_pop,
    output logic                             rd_valid,
    output trig_sample_pkg::word_t           rd_data,
    output trig_ctrl_pkg::word_kind_t        rd_kind,
    output logic                             space_ok,
    output logic                             fifo_full
);
    import trig_sample_pkg::*;
    import trig_ctrl_pkg::*;

    localparam int DEPTH     = `TRIG_FIFO_DEPTH;
    localparam int PTR_W     = $clog2(DEPTH);
    localparam int CNT_W     = PTR_W + 1;
    localparam int EVT_WORDS = `TRIG_EVT_WORDS;

    word_t            data_mem [DEPTH];
    word_kind_t       kind_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en && (count != CNT_W'(DEPTH));
    assign do_rd = rd_pop && rd_valid;

    // head is visible without a read cycle
    assign rd_valid = (count != '0);
    assign rd_data  = data_mem[rd_ptr];
    assign rd_kind  = kind_mem[rd_ptr];

    // room for a whole event or nothing
    assign free     = CNT_W'(DEPTH) - count;
    assign space_ok = (free >= CNT_W'(EVT_WORDS));

    always_ff @(posedge axis_aclk)
    begin
        if (do_wr)
        begin
            data_mem[wr_ptr] <= wr_data;
            kind_mem[wr_ptr] <= wr_kind;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            fifo_full <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count     <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
            fifo_full <= ~space_ok;
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_packer.sv ====
`default_nettype none

module frame_packer (
    input  wire                              axis_aclk,
    input  wire                              rst,
    input  wire                              rd_valid,
    input  wire trig_sample_pkg::word_t      rd_data,
    input  wire trig_ctrl_pkg::word_kind_t   rd_kind,
    output logic                             rd_pop,
    output logic                             out_valid,
    output trig_sample_pkg::word_t           out_data,
    output logic                             out_user,
    output logic                             out_last,
    input  wire                              out_ready
);
    import trig_ctrl_pkg::*;

    logic load;

    // output slot is free or being taken this cycle
    assign load   = rd_valid && (!out_valid || out_ready);
    assign rd_pop = load;

    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            out_user  <= 1'b0;
            out_last  <= 1'b0;
        end
        else if (load)
        begin
            out_valid <= 1'b1;
            out_user  <= (rd_kind == HEADER);
            out_last  <= (rd_kind == TAIL);
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;
            out_user  <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    // held while the sink stalls
    always_ff @(posedge axis_aclk)
    begin
        if (load)
            out_data <= rd_data;
    end

endmodule

`default_nettype wire

// ==== source/min_trigger_top.sv ====
`default_nettype none

module min_trigger_top (
    input  wire                            axis_aclk,
    input  wire                            rst,
    input  wire                            in_valid,
    input  wire trig_sample_pkg::word_t    in_data,
    input  wire                            out_ready,
    output logic                           out_valid,
    output trig_sample_pkg::word_t         out_data,
    output logic                           out_user,
    output logic                           out_last,
    output logic                           fifo_full
);
    import trig_sample_pkg::*;
    import trig_ctrl_pkg::*;

    logic       word_valid;
    sample_t    word_min;
    word_t      delayed_word;
    logic       base_ready;
    sample_t    baseline;
    logic       wr_en;
    word_t      wr_data;
    word_kind_t wr_kind;
    logic       space_ok;
    logic       rd_valid;
    word_t      rd_data;
    word_kind_t rd_kind;
    logic       rd_pop;

    // input side
    adc_word_front u_front (
        .axis_aclk    (axis_aclk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .word_valid   (word_valid),
        .word_min     (word_min),
        .delayed_word (delayed_word)
    );

    baseline_tracker u_base (
        .axis_aclk  (axis_aclk),
        .rst        (rst),
        .word_valid (word_valid),
        .word_min   (word_min),
        .base_ready (base_ready),
        .baseline   (baseline)
    );

    trigger_fsm u_trig (
        .axis_aclk    (axis_aclk),
        .rst          (rst),
        .word_valid   (word_valid),
        .word_min     (word_min),
        .delayed_word (delayed_word),
        .base_ready   (base_ready),
        .baseline     (baseline),
        .space_ok     (space_ok),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .wr_kind      (wr_kind)
    );

    // output side
    event_fifo u_fifo (
        .axis_aclk (axis_aclk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .wr_kind   (wr_kind),
        .rd_pop    (rd_pop),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_kind   (rd_kind),
        .space_ok  (space_ok),
        .fifo_full (fifo_full)
    );

    frame_packer u_pack (
        .axis_aclk (axis_aclk),
        .rst       (rst),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_kind   (rd_kind),
        .rd_pop    (rd_pop),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_user  (out_user),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// ==== tb/min_trigger_asserts.sv ====
`default_nettype none

`include "trig_cfg.svh"

module min_trigger_asserts (
    input wire                                axis_aclk,
    input wire                                rst,
    input wire                                hs_valid,
    input wire                                hs_ready,
    input wire trig_sample_pkg::word_t        hs_data,
    input wire                                hs_user,
    input wire                                hs_last,
    input wire                                push,
    input wire                                pop,
    input wire [$clog2(`TRIG_FIFO_DEPTH):0]   fill
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = `TRIG_FIFO_DEPTH;

    // a stalled word keeps its data and flags
    property hold_under_stall;
        @(posedge axis_aclk) disable iff (rst)
        (hs_valid && !hs_ready) |=>
            (hs_valid && $stable(hs_data) && $stable(hs_user) && $stable(hs_last));
    endproperty

    a_hold: assert property (hold_under_stall)
        else $error("output word changed while the sink stalled");

    a_flags: assert property (@(posedge axis_aclk) disable iff (rst) !(hs_user && hs_last))
        else $error("user and last flags high on the same word");

    a_no_overflow: assert property (@(posedge axis_aclk) disable iff (rst) push |-> (fill < DEPTH))
        else $error("write into a full FIFO");

    a_no_underflow: assert property (@(posedge axis_aclk) disable iff (rst) pop |-> (fill != 0))
        else $error("read from an empty FIFO");

endmodule

// handshake checks on the output register
bind frame_packer min_trigger_asserts u_pack_asserts (
    .axis_aclk (axis_aclk),
    .rst       (rst),
    .hs_valid  (out_valid),
    .hs_ready  (out_ready),
    .hs_data   (out_data),
    .hs_user   (out_user),
    .hs_last   (out_last),
    .push      (1'b0),
    .pop       (1'b0),
    .fill      ('0)
);

// occupancy checks on the event buffer
bind event_fifo min_trigger_asserts u_fifo_asserts (
    .axis_aclk (axis_aclk),
    .rst       (rst),
    .hs_valid  (1'b0),
    .hs_ready  (1'b1),
    .hs_data   ('0),
    .hs_user   (1'b0),
    .hs_last   (1'b0),
    .push      (wr_en),
    .pop       (rd_pop),
    .fill      (count)
);

`default_nettype wire

// ==== tb/min_trigger_tb.sv ====
`default_nettype none

`include "trig_cfg.svh"

module min_trigger_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import trig_sample_pkg::*;
    import trig_ctrl_pkg::*;

    typedef enum {RDY_ALWAYS, RDY_RANDOM, RDY_LOW} ready_mode_t;

    typedef struct {
        int          gap;
        int          depth;
        int          width;
        ready_mode_t mode;
        int          exp_evt;
    } row_t;

    localparam int N_ROWS    = 16;
    localparam int PRE       = `TRIG_PRE_WORDS;
    localparam int CAP       = `TRIG_CAP_WORDS;
    localparam int EVT_WORDS = `TRIG_EVT_WORDS;
    localparam int N_BASE    = 1 << `TRIG_BASE_LOG2;
    localparam int DEPTH     = `TRIG_FIFO_DEPTH;
    localparam int LW        = `TRIG_LANE_W;
    localparam int SW        = `TRIG_SAMPLE_W;
    localparam int SKIP      = LW - SW;
    localparam int NOISE_LO  = -96;
    localparam int NOISE_HI  = -64;

    // gap words, depth below baseline, pulse width, ready mode, expected frames
    row_t rows [N_ROWS] = '{
        '{20,    0,   0, RDY_ALWAYS, 0},
        '{30,    200, 1, RDY_ALWAYS, 0},
        '{30,    201, 1, RDY_ALWAYS, 1},
        '{30,    400, 3, RDY_RANDOM, 1},
        // starts inside the previous capture window
        '{8,     400, 2, RDY_RANDOM, 0},
        '{40,    300, 1, RDY_RANDOM, 1},
        '{40,    0,   0, RDY_ALWAYS, 0},
        // sink stalled, three events fit and the rest are dropped
        '{30,    300, 1, RDY_LOW,    1},
        '{30,    300, 1, RDY_LOW,    1},
        '{30,    300, 1, RDY_LOW,    1},
        '{30,    300, 1, RDY_LOW,    0},
        '{30,    300, 2, RDY_LOW,    0},
        '{80,    0,   0, RDY_ALWAYS, 0},
        // long gap so the time stamp wraps
        '{65200, 250, 1, RDY_ALWAYS, 1},
        '{30,    500, 1, RDY_RANDOM, 1},
        '{40,    0,   0, RDY_ALWAYS, 0}
    };

    logic  axis_aclk;
    logic  rst;
    logic  in_valid;
    word_t in_data;
    logic  out_ready;
    logic  out_valid;
    word_t out_data;
    logic  out_user;
    logic  out_last;
    logic  fifo_full;

    // words sent, tagged with their table row
    word_t sent [$];
    int    sent_row [$];
    word_t exp_data [$];
    logic  exp_user [$];
    logic  exp_last [$];

    int    mismatches = 0;
    int    failures = 0;
    int    frames_got = 0;
    int    evt_row [N_ROWS];
    bit    full_seen = 1'b0;

    // reference model state
    bit          saved_valid = 1'b0;
    int          m_idx = 0;
    int          m_base_cnt = 0;
    bit          m_base_ready = 1'b0;
    int          m_baseline = 0;
    trig_state_t m_state = WAIT_BASE;
    int          m_cap = 0;
    int          m_trig_k = 0;
    int          m_evt = 0;
    int          m_writes = 0;
    int          m_hs = 0;
    bit          m_full_q = 1'b0;

    min_trigger_top DUT (
        .axis_aclk (axis_aclk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_user  (out_user),
        .out_last  (out_last),
        .fifo_full (fifo_full)
    );

    initial
    begin
        axis_aclk = 1'b0;
        forever #2 axis_aclk = ~axis_aclk;
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    // signed sample from the upper bits of a lane
    function automatic int lane_sample(input word_t w, input int l);
        logic [SW-1:0] raw;
        raw = w[l*LW + SKIP +: SW];
        return int'($signed(raw));
    endfunction

    function automatic int word_min_of(input word_t w);
        int m;
        m = lane_sample(w, 0);
        for (int l = 1; l < `TRIG_LANES; l++)
        begin
            if (lane_sample(w, l) < m)
            begin
                m = lane_sample(w, l);
            end
        end
        return m;
    endfunction

    // floor of the mean of the first word minima
    function automatic int floor_mean();
        int sum;
        int q;
        sum = 0;
        for (int i = 0; i < N_BASE; i++)
        begin
            sum += word_min_of(sent[i]);
        end
        q = sum / N_BASE;
        if ((sum % N_BASE) != 0 && sum < 0)
        begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic word_t noise_word(input int level, input int pulse_lane,
                                         input int pulse_val);
        word_t w;
        int    s;
        w = '0;
        for (int l = 0; l < `TRIG_LANES; l++)
        begin
            s = (l == pulse_lane) ? pulse_val : level + int'($urandom_range(15, 0));
            w[l*LW + SKIP +: SW] = s[SW-1:0];
            w[l*LW +: SKIP]      = $urandom();
        end
        return w;
    endfunction

    task automatic drive_ready(input ready_mode_t mode);
        case (mode)
            RDY_ALWAYS: out_ready <= 1'b1;
            RDY_RANDOM: out_ready <= $urandom_range(1, 0);
            default:    out_ready <= 1'b0;
        endcase
    endtask

    // idle strobe cycles are mixed in at random
    task automatic send_word(input word_t w, input int row, input ready_mode_t mode);
        bit done;
        done = 1'b0;
        while (!done)
        begin
            @(posedge axis_aclk);
            drive_ready(mode);
            if ($urandom_range(3, 0) == 0)
            begin
                in_valid <= 1'b0;
            end
            else
            begin
                in_valid <= 1'b1;
                in_data  <= w;
                done     = 1'b1;
            end
        end
        sent.push_back(w);
        sent_row.push_back(row);
    endtask

    task automatic run_row(input int r);
        int base;
        int level;
        base = 0;
        for (int i = 0; i < rows[r].gap; i++)
        begin
            level = (sent.size() % 2 == 0) ? NOISE_LO : NOISE_HI;
            send_word(noise_word(level, -1, 0), r, rows[r].mode);
        end
        if (rows[r].width > 0)
        begin
            base = floor_mean();
        end
        for (int i = 0; i < rows[r].width; i++)
        begin
            level = (sent.size() % 2 == 0) ? NOISE_LO : NOISE_HI;
            send_word(noise_word(level, $urandom_range(3, 0), base - rows[r].depth),
                      r, rows[r].mode);
        end
    endtask

    task automatic push_expected(input word_t w, input logic user, input logic last);
        exp_data.push_back(w);
        exp_user.push_back(user);
        exp_last.push_back(last);
        m_writes++;
    endtask

    // one clock of the trigger rules, evaluated where outputs are stable
    task automatic step_model();
        int    fifo_cnt;
        int    level;
        int    wmin;
        bit    space_ok;
        bit    fire;
        word_t hdr;
        // stored words exclude the one held in the output register
        fifo_cnt = m_writes - m_hs - int'(out_valid);
        space_ok = (DEPTH - fifo_cnt) >= EVT_WORDS;
        check_val("fifo_full", fifo_full, m_full_q);
        m_full_q = !space_ok;
        if (fifo_full)
        begin
            full_seen = 1'b1;
        end
        wmin  = saved_valid ? word_min_of(sent[m_idx]) : 0;
        level = m_baseline - `TRIG_THRESHOLD;
        if (level < -2048)
        begin
            level = -2048;
        end
        fire = saved_valid && m_state == ARMED && m_idx >= PRE && wmin < level && space_ok;
        case (m_state)
            WAIT_BASE:
            begin
                if (m_base_ready)
                begin
                    m_state = ARMED;
                end
            end
            ARMED:
            begin
                if (fire)
                begin
                    hdr          = '0;
                    hdr[15:0]    = m_idx[15:0];
                    hdr[27:16]   = m_baseline[11:0];
                    hdr[63:32]   = m_evt;
                    push_expected(hdr, 1'b1, 1'b0);
                    evt_row[sent_row[m_idx]]++;
                    m_evt++;
                    m_trig_k = m_idx;
                    m_cap    = 0;
                    m_state  = CAPTURE;
                end
            end
            default:
            begin
                if (saved_valid)
                begin
                    push_expected(sent[m_trig_k - PRE + m_cap], 1'b0, m_cap == CAP - 1);
                    if (m_cap == CAP - 1)
                    begin
                        m_state = ARMED;
                    end
                    m_cap++;
                end
            end
        endcase
        if (saved_valid && m_base_cnt < N_BASE)
        begin
            m_base_cnt++;
            if (m_base_cnt == N_BASE)
            begin
                m_baseline   = floor_mean();
                m_base_ready = 1'b1;
            end
        end
        if (saved_valid)
        begin
            m_idx++;
        end
    endtask

    task automatic check_output();
        if (out_valid && out_ready)
        begin
            if (exp_data.size() == 0)
            begin
                $display("unexpected output word 0x%h with no frame pending", out_data);
                failures++;
            end
            else
            begin
                check_val("out_data", out_data, exp_data.pop_front());
                check_val("out_user", out_user, exp_user.pop_front());
                check_val("out_last", out_last, exp_last.pop_front());
            end
            if (out_last)
            begin
                frames_got++;
            end
            m_hs++;
        end
    endtask

    always @(negedge axis_aclk)
    begin
        if (!rst)
        begin
            step_model();
            check_output();
        end
        // word on the bus now shows up as word_valid next cycle
        saved_valid = in_valid;
    end

    initial
    begin
        int exp_frames;
        void'($urandom(32'h51dc99ec));
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        repeat (4) @(posedge axis_aclk);
        rst <= 1'b0;
        @(negedge axis_aclk);
        check_val("out_valid", out_valid, 1'b0);
        check_val("out_user", out_user, 1'b0);
        check_val("out_last", out_last, 1'b0);
        for (int r = 0; r < N_ROWS; r++)
        begin
            run_row(r);
        end
        @(posedge axis_aclk);
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        while (exp_data.size() != 0 || out_valid)
        begin
            @(negedge axis_aclk);
        end
        repeat (10) @(negedge axis_aclk);
        exp_frames = 0;
        for (int r = 0; r < N_ROWS; r++)
        begin
            check_val($sformatf("row %0d events", r), evt_row[r], rows[r].exp_evt);
            exp_frames += rows[r].exp_evt;
        end
        check_val("frames", frames_got, exp_frames);
        if (!full_seen)
        begin
            $display("fifo_full never went high while the output was stalled");
            failures++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

    // limit scales with the number of words in the table
    initial
    begin
        longint limit;
        int     words;
        words = 0;
        for (int r = 0; r < N_ROWS; r++)
        begin
            words += rows[r].gap + rows[r].width;
        end
        limit = (longint'(words) * 2 + 2000) * 4;
        #(limit);
        $display("watchdog timeout after %0d ns, the run did not finish", limit);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+source
source/trig_sample_pkg.sv
source/trig_ctrl_pkg.sv
source/adc_word_front.sv
source/baseline_tracker.sv
source/trigger_fsm.sv
source/event_fifo.sv
source/frame_packer.sv
source/min_trigger_top.sv
tb/min_trigger_asserts.sv
tb/min_trigger_tb.sv
